// File: source/mm_pkg.sv
// Shared widths, sizes and word types for the matrix-multiply complex
`default_nettype none

package mm_pkg;

  // Memory word and scratchpad address
  localparam int unsigned DataW = 32;
  localparam int unsigned AddrW = 8;

  // Operands are the signed low half of a word
  localparam int unsigned OpW = 16;

  // Dimension fields hold size minus one
  localparam int unsigned DimW = 2;
  localparam int unsigned MaxDim = 4;

  // Master 0 is the host, master 1 the engine
  localparam int unsigned NumMasters = 2;

  typedef logic [DataW-1:0] word_t;
  typedef logic [AddrW-1:0] addr_t;
  typedef logic [DimW-1:0] dim_t;

endpackage

`default_nettype wire

// File: source/mm_scratchpad.sv
// Single-port word scratchpad with a registered read port
`timescale 1ns/1ps
`default_nettype none

module mm_scratchpad
  import mm_pkg::*;
(
  input  logic  clk_i,
  input  logic  req_i,
  input  logic  we_i,
  input  addr_t addr_i,
  input  word_t wdata_i,
  output word_t rdata_o
);

  localparam int unsigned Depth = 2 ** AddrW;

  word_t mem_q [Depth];
  word_t rdata_q;

  // Write on the edge, read data appears the cycle after the request
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        rdata_q <= mem_q[addr_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: source/mm_tcdm_arbiter.sv
// Round-robin arbiter placing two masters on the scratchpad port
`timescale 1ns/1ps
`default_nettype none

module mm_tcdm_arbiter
  import mm_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic  [NumMasters-1:0]       req_i,
  input  logic  [NumMasters-1:0]       we_i,
  input  addr_t [NumMasters-1:0]       addr_i,
  input  word_t [NumMasters-1:0]       wdata_i,
  output logic  [NumMasters-1:0]       gnt_o,
  output logic  [NumMasters-1:0]       rvalid_o,
  output word_t [NumMasters-1:0]       rdata_o,
  output logic                         mem_req_o,
  output logic                         mem_we_o,
  output addr_t                        mem_addr_o,
  output word_t                        mem_wdata_o,
  input  word_t                        mem_rdata_i
);

  localparam int unsigned IdxW = $clog2(NumMasters);

  logic [IdxW-1:0] last_q;
  logic [IdxW-1:0] sel;
  logic [IdxW-1:0] owner_q;
  logic            rvalid_q;
  logic            any_req;

  assign any_req = |req_i;

  // Contention goes to the master that did not win last time
  always_comb begin
    if (req_i[0] && req_i[1]) begin
      sel = ~last_q;
    end else if (req_i[1]) begin
      sel = 1'b1;
    end else begin
      sel = 1'b0;
    end
  end

  assign mem_req_o   = any_req;
  assign mem_we_o    = we_i[sel];
  assign mem_addr_o  = addr_i[sel];
  assign mem_wdata_o = wdata_i[sel];

  always_comb begin
    for (int m = 0; m < NumMasters; m++) begin
      gnt_o[m]    = any_req && (sel == IdxW'(m));
      rvalid_o[m] = rvalid_q && (owner_q == IdxW'(m));
      rdata_o[m]  = mem_rdata_i;
    end
  end

  // Last winner starts on the engine so the host goes first
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q   <= 1'b1;
      owner_q  <= '0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= any_req && !we_i[sel];
      if (any_req) begin
        last_q <= sel;
      end
      // Read owner steers next cycle's response
      if (any_req && !we_i[sel]) begin
        owner_q <= sel;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/mm_engine.sv
// Matrix-multiply engine computing Z = X*W through one scratchpad port
`timescale 1ns/1ps
`default_nettype none

module mm_engine
  import mm_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  en_i,
  input  logic  start_i,
  input  addr_t x_addr_i,
  input  addr_t w_addr_i,
  input  addr_t z_addr_i,
  input  dim_t  m_i,
  input  dim_t  k_i,
  input  dim_t  n_i,
  output logic  busy_o,
  output logic  evt_o,
  output logic  mem_req_o,
  output logic  mem_we_o,
  output addr_t mem_addr_o,
  output word_t mem_wdata_o,
  input  logic  mem_gnt_i,
  input  logic  mem_rvalid_i,
  input  word_t mem_rdata_i
);

  localparam int unsigned CntW = $clog2(MaxDim);

  typedef enum logic [2:0] {
    StIdle,
    StReadX,
    StWaitX,
    StReadW,
    StWaitW,
    StWriteZ
  } state_e;

  state_e state_q, state_d;

  // Loop counters and control flags
  logic [CntW-1:0] i_q, j_q, p_q;
  logic            last_i, last_j, last_p;
  logic            pend_q;
  logic            evt_q;
  logic            req_state;
  logic            accept;

  // Latched job description
  addr_t x_base_q, w_base_q, z_base_q;
  dim_t  m_q, k_q, n_q;
  addr_t k_len, n_len;

  // Datapath
  logic signed [OpW-1:0]   x_op_q;
  logic signed [OpW-1:0]   w_op;
  logic signed [2*OpW-1:0] prod;
  word_t                   acc_q;
  word_t                   acc_sum;

  assign accept = (state_q == StIdle) && start_i;

  assign last_i = (i_q == CntW'(m_q));
  assign last_j = (j_q == CntW'(n_q));
  assign last_p = (p_q == CntW'(k_q));

  assign k_len = addr_t'(k_q) + addr_t'(1);
  assign n_len = addr_t'(n_q) + addr_t'(1);

  // Sign-extended 16x16 product, sum wraps at 32 bits
  assign w_op    = mem_rdata_i[OpW-1:0];
  assign prod    = x_op_q * w_op;
  assign acc_sum = acc_q + word_t'(prod);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      StIdle: begin
        if (start_i) begin
          state_d = StReadX;
        end
      end
      StReadX: begin
        if (mem_gnt_i) begin
          state_d = StWaitX;
        end
      end
      StWaitX: begin
        if (mem_rvalid_i) begin
          state_d = StReadW;
        end
      end
      StReadW: begin
        if (mem_gnt_i) begin
          state_d = StWaitW;
        end
      end
      StWaitW: begin
        if (mem_rvalid_i) begin
          state_d = last_p ? StWriteZ : StReadX;
        end
      end
      StWriteZ: begin
        if (mem_gnt_i) begin
          state_d = (last_i && last_j) ? StIdle : StReadX;
        end
      end
      default: state_d = StIdle;
    endcase
  end

  // A fresh request needs the enable, a pending one stays up until granted
  assign req_state = (state_q == StReadX) || (state_q == StReadW) ||
                     (state_q == StWriteZ);
  assign mem_req_o = req_state && (en_i || pend_q);
  assign mem_we_o  = (state_q == StWriteZ);

  always_comb begin
    unique case (state_q)
      StReadW:  mem_addr_o = w_base_q + addr_t'(p_q) * n_len + addr_t'(j_q);
      StWriteZ: mem_addr_o = z_base_q + addr_t'(i_q) * n_len + addr_t'(j_q);
      default:  mem_addr_o = x_base_q + addr_t'(i_q) * k_len + addr_t'(p_q);
    endcase
  end

  assign mem_wdata_o = acc_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= StIdle;
      pend_q  <= 1'b0;
      evt_q   <= 1'b0;
      i_q     <= '0;
      j_q     <= '0;
      p_q     <= '0;
    end else begin
      state_q <= state_d;
      pend_q  <= mem_req_o && !mem_gnt_i;
      evt_q   <= (state_q == StWriteZ) && mem_gnt_i && last_i && last_j;
      if (accept) begin
        i_q <= '0;
        j_q <= '0;
        p_q <= '0;
      end else if ((state_q == StWaitW) && mem_rvalid_i && !last_p) begin
        p_q <= p_q + 1'b1;
      end else if ((state_q == StWriteZ) && mem_gnt_i) begin
        // Next column, or first column of the next row
        p_q <= '0;
        if (last_j) begin
          j_q <= '0;
          i_q <= i_q + 1'b1;
        end else begin
          j_q <= j_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      x_base_q <= x_addr_i;
      w_base_q <= w_addr_i;
      z_base_q <= z_addr_i;
      m_q      <= m_i;
      k_q      <= k_i;
      n_q      <= n_i;
      acc_q    <= '0;
    end
    if ((state_q == StWaitX) && mem_rvalid_i) begin
      x_op_q <= mem_rdata_i[OpW-1:0];
    end
    if ((state_q == StWaitW) && mem_rvalid_i) begin
      acc_q <= acc_sum;
    end
    // Fresh sum for the next Z element
    if ((state_q == StWriteZ) && mem_gnt_i) begin
      acc_q <= '0;
    end
  end

  assign busy_o = (state_q != StIdle);
  assign evt_o  = evt_q;

endmodule

`default_nettype wire

// File: source/mm_complex.sv
// Matrix-multiply complex with host port, engine and shared scratchpad
`timescale 1ns/1ps
`default_nettype none

module mm_complex
  import mm_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  fetch_enable_i,
  input  logic  start_i,
  input  addr_t x_addr_i,
  input  addr_t w_addr_i,
  input  addr_t z_addr_i,
  input  dim_t  m_i,
  input  dim_t  k_i,
  input  dim_t  n_i,
  input  logic  host_req_i,
  input  logic  host_we_i,
  input  addr_t host_addr_i,
  input  word_t host_wdata_i,
  output logic  host_gnt_o,
  output logic  host_rvalid_o,
  output word_t host_rdata_o,
  output logic  busy_o,
  output logic  evt_o
);

  logic enable_q;

  // Engine side of the shared port
  logic  eng_req, eng_we, eng_gnt, eng_rvalid;
  addr_t eng_addr;
  word_t eng_wdata;

  // Arbiter master vectors
  logic  [NumMasters-1:0] m_req, m_we, m_gnt, m_rvalid;
  addr_t [NumMasters-1:0] m_addr;
  word_t [NumMasters-1:0] m_wdata, m_rdata;

  // Scratchpad port
  logic  mem_req, mem_we;
  addr_t mem_addr;
  word_t mem_wdata, mem_rdata;

  // Stall enable for the engine, one cycle behind the input
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_q <= 1'b0;
    end else begin
      enable_q <= fetch_enable_i;
    end
  end

  mm_engine i_engine (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .en_i         ( enable_q   ),
    .start_i      ( start_i    ),
    .x_addr_i     ( x_addr_i   ),
    .w_addr_i     ( w_addr_i   ),
    .z_addr_i     ( z_addr_i   ),
    .m_i          ( m_i        ),
    .k_i          ( k_i        ),
    .n_i          ( n_i        ),
    .busy_o       ( busy_o     ),
    .evt_o        ( evt_o      ),
    .mem_req_o    ( eng_req    ),
    .mem_we_o     ( eng_we     ),
    .mem_addr_o   ( eng_addr   ),
    .mem_wdata_o  ( eng_wdata  ),
    .mem_gnt_i    ( eng_gnt    ),
    .mem_rvalid_i ( eng_rvalid ),
    .mem_rdata_i  ( m_rdata[1] )
  );

  // Host on master 0, engine on master 1
  assign m_req   = {eng_req, host_req_i};
  assign m_we    = {eng_we, host_we_i};
  assign m_addr  = {eng_addr, host_addr_i};
  assign m_wdata = {eng_wdata, host_wdata_i};

  assign host_gnt_o    = m_gnt[0];
  assign host_rvalid_o = m_rvalid[0];
  assign host_rdata_o  = m_rdata[0];
  assign eng_gnt       = m_gnt[1];
  assign eng_rvalid    = m_rvalid[1];

  mm_tcdm_arbiter i_arbiter (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .req_i       ( m_req     ),
    .we_i        ( m_we      ),
    .addr_i      ( m_addr    ),
    .wdata_i     ( m_wdata   ),
    .gnt_o       ( m_gnt     ),
    .rvalid_o    ( m_rvalid  ),
    .rdata_o     ( m_rdata   ),
    .mem_req_o   ( mem_req   ),
    .mem_we_o    ( mem_we    ),
    .mem_addr_o  ( mem_addr  ),
    .mem_wdata_o ( mem_wdata ),
    .mem_rdata_i ( mem_rdata )
  );

  mm_scratchpad i_scratchpad (
    .clk_i   ( clk_i     ),
    .req_i   ( mem_req   ),
    .we_i    ( mem_we    ),
    .addr_i  ( mem_addr  ),
    .wdata_i ( mem_wdata ),
    .rdata_o ( mem_rdata )
  );

endmodule

`default_nettype wire

// File: testbench/tb_mm_complex.sv
// Testbench for the matrix-multiply complex with random jobs, host traffic and a memory model
`timescale 1ns/1ps
`default_nettype none

module tb_mm_complex
  import mm_pkg::*;
();

  localparam int unsigned GntTimeout = 50;
  localparam int unsigned JobTimeout = 3000;
  localparam int unsigned NumJobs    = 24;
  // Four 64-word regions for X, W, Z and host scratch
  localparam int XRegion = 0;
  localparam int WRegion = 64;
  localparam int ZRegion = 128;
  localparam int SRegion = 192;

  logic  clk_i, rst_ni, fetch_enable_i, start_i;
  addr_t x_addr_i, w_addr_i, z_addr_i;
  dim_t  m_i, k_i, n_i;
  logic  host_req_i, host_we_i, host_gnt_o, host_rvalid_o;
  addr_t host_addr_i;
  word_t host_wdata_i, host_rdata_o;
  logic  busy_o, evt_o;

  word_t model_mem [256];
  int    value_errors;
  int    timeout_errors;
  int    evt_count;
  int    jobs_done;

  mm_complex uut (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .fetch_enable_i ( fetch_enable_i ),
    .start_i        ( start_i        ),
    .x_addr_i       ( x_addr_i       ),
    .w_addr_i       ( w_addr_i       ),
    .z_addr_i       ( z_addr_i       ),
    .m_i            ( m_i            ),
    .k_i            ( k_i            ),
    .n_i            ( n_i            ),
    .host_req_i     ( host_req_i     ),
    .host_we_i      ( host_we_i      ),
    .host_addr_i    ( host_addr_i    ),
    .host_wdata_i   ( host_wdata_i   ),
    .host_gnt_o     ( host_gnt_o     ),
    .host_rvalid_o  ( host_rvalid_o  ),
    .host_rdata_o   ( host_rdata_o   ),
    .busy_o         ( busy_o         ),
    .evt_o          ( evt_o          )
  );

  always #5 clk_i = ~clk_i;

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("Error at time %0t: %s got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("Error at time %0t: %s got %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    timeout_errors++;
    $display("Timeout at time %0t: %s never happened", $time, what);
  endtask

  // Completion pulses, busy has to be low in the pulse cycle
  always @(negedge clk_i) begin
    if (rst_ni === 1'b1 && evt_o === 1'b1) begin
      evt_count++;
      check_bit("busy_o", busy_o, 1'b0);
    end
  end

  function automatic addr_t word_addr(input int base, input int offset);
    return addr_t'(base + offset);
  endfunction

  function automatic word_t random_operand();
    word_t w;
    w = $urandom;
    // Most negative operand now and then, so that sums wrap
    if ($urandom_range(7) == 0) begin
      w[OpW-1:0] = 16'h8000;
    end
    return w;
  endfunction

  task automatic wait_host_grant(input string what);
    int unsigned cnt;
    cnt = 0;
    #1;
    while (host_gnt_o !== 1'b1 && cnt < GntTimeout) begin
      @(negedge clk_i);
      #1;
      cnt++;
    end
    if (host_gnt_o !== 1'b1) begin
      report_timeout(what);
    end
  endtask

  task automatic host_write(input addr_t addr, input word_t data);
    @(negedge clk_i);
    host_req_i   = 1'b1;
    host_we_i    = 1'b1;
    host_addr_i  = addr;
    host_wdata_i = data;
    wait_host_grant("grant of a host write");
    @(negedge clk_i);
    host_req_i = 1'b0;
    model_mem[addr] = data;
    #1;
    check_bit("host_rvalid_o", host_rvalid_o, 1'b0);
  endtask

  // Read data must come with rvalid in the cycle after the grant
  task automatic host_read_check(input addr_t addr);
    @(negedge clk_i);
    host_req_i   = 1'b1;
    host_we_i    = 1'b0;
    host_addr_i  = addr;
    host_wdata_i = '0;
    wait_host_grant("grant of a host read");
    @(negedge clk_i);
    host_req_i = 1'b0;
    #1;
    check_bit("host_rvalid_o", host_rvalid_o, 1'b1);
    check_word("host_rdata_o", host_rdata_o, model_mem[addr]);
  endtask

  task automatic host_traffic(input int x, input int len, input int count);
    repeat (count) begin
      if ($urandom_range(1) == 0) begin
        host_read_check(word_addr(x, $urandom_range(len - 1)));
      end else begin
        host_write(word_addr(SRegion, $urandom_range(63)), $urandom);
      end
    end
  endtask

  task automatic fill_operands(input int x, input int w, input int m, input int k, input int n);
    for (int idx = 0; idx < m * k; idx++) begin
      host_write(word_addr(x, idx), random_operand());
    end
    for (int idx = 0; idx < k * n; idx++) begin
      host_write(word_addr(w, idx), random_operand());
    end
  endtask

  // Z = X*W with sign-extended 16-bit operands and 32-bit wrapping sums
  task automatic compute_model(input int x, input int w, input int z,
                               input int m, input int k, input int n);
    word_t             sum;
    logic [OpW-1:0]    x_op, w_op;
    logic [DataW-1:0]  x_ext, w_ext;
    for (int i = 0; i < m; i++) begin
      for (int j = 0; j < n; j++) begin
        sum = '0;
        for (int p = 0; p < k; p++) begin
          x_op  = model_mem[word_addr(x, i * k + p)][OpW-1:0];
          w_op  = model_mem[word_addr(w, p * n + j)][OpW-1:0];
          x_ext = {{(DataW-OpW){x_op[OpW-1]}}, x_op};
          w_ext = {{(DataW-OpW){w_op[OpW-1]}}, w_op};
          sum   = sum + x_ext * w_ext;
        end
        model_mem[word_addr(z, i * n + j)] = sum;
      end
    end
  endtask

  task automatic start_job(input int x, input int w, input int z,
                           input int m, input int k, input int n);
    @(negedge clk_i);
    check_bit("busy_o", busy_o, 1'b0);
    start_i  = 1'b1;
    x_addr_i = addr_t'(x);
    w_addr_i = addr_t'(w);
    z_addr_i = addr_t'(z);
    m_i      = dim_t'(m - 1);
    k_i      = dim_t'(k - 1);
    n_i      = dim_t'(n - 1);
    @(negedge clk_i);
    start_i = 1'b0;
    #1;
    check_bit("busy_o", busy_o, 1'b1);
  endtask

  task automatic wait_job_done(input int target);
    int unsigned cnt;
    cnt = 0;
    while (evt_count < target && cnt < JobTimeout) begin
      @(negedge clk_i);
      #1;
      cnt++;
    end
    if (evt_count < target) begin
      report_timeout("evt_o at the end of a job");
    end
  endtask

  task automatic check_job_end(input int z, input int m, input int n);
    repeat (4) @(negedge clk_i);
    #1;
    check_bit("busy_o", busy_o, 1'b0);
    check_word("evt_count", word_t'(evt_count), word_t'(jobs_done));
    for (int idx = 0; idx < m * n; idx++) begin
      host_read_check(word_addr(z, idx));
    end
  endtask

  task automatic random_job(input bit traffic, input bit restart, input bit stall);
    int m, k, n, x, w, z;
    m = $urandom_range(MaxDim, 1);
    k = $urandom_range(MaxDim, 1);
    n = $urandom_range(MaxDim, 1);
    x = XRegion + int'($urandom_range(64 - m * k));
    w = WRegion + int'($urandom_range(64 - k * n));
    z = ZRegion + int'($urandom_range(64 - m * n));
    if (stall) begin
      @(negedge clk_i);
      fetch_enable_i = 1'b0;
    end
    fill_operands(x, w, m, k, n);
    compute_model(x, w, z, m, k, n);
    jobs_done++;
    start_job(x, w, z, m, k, n);
    if (restart) begin
      // Second start while busy, pointing at other operands
      @(negedge clk_i);
      start_i  = 1'b1;
      x_addr_i = addr_t'(WRegion);
      z_addr_i = addr_t'(SRegion);
      @(negedge clk_i);
      start_i = 1'b0;
    end
    if (stall) begin
      repeat ($urandom_range(30, 5)) begin
        @(negedge clk_i);
        #1;
        check_bit("busy_o", busy_o, 1'b1);
        check_bit("evt_o", evt_o, 1'b0);
      end
      host_traffic(x, m * k, 6);
      check_word("evt_count", word_t'(evt_count), word_t'(jobs_done - 1));
      @(negedge clk_i);
      fetch_enable_i = 1'b1;
    end
    if (traffic) begin
      fork
        wait_job_done(jobs_done);
        host_traffic(x, m * k, 12);
      join
    end else begin
      wait_job_done(jobs_done);
    end
    check_job_end(z, m, n);
  endtask

  initial begin
    void'($urandom(17));
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    fetch_enable_i = 1'b0;
    start_i        = 1'b0;
    x_addr_i       = '0;
    w_addr_i       = '0;
    z_addr_i       = '0;
    m_i            = '0;
    k_i            = '0;
    n_i            = '0;
    host_req_i     = 1'b0;
    host_we_i      = 1'b0;
    host_addr_i    = '0;
    host_wdata_i   = '0;
    value_errors   = 0;
    timeout_errors = 0;
    evt_count      = 0;
    jobs_done      = 0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni         = 1'b1;
    fetch_enable_i = 1'b1;
    #1;
    check_bit("busy_o", busy_o, 1'b0);
    check_bit("evt_o", evt_o, 1'b0);
    check_bit("host_gnt_o", host_gnt_o, 1'b0);
    check_bit("host_rvalid_o", host_rvalid_o, 1'b0);
    // Host write and read-back on the scratch region
    for (int a = 0; a < 64; a++) begin
      host_write(word_addr(SRegion, a), $urandom);
    end
    repeat (64) begin
      if ($urandom_range(2) == 0) begin
        host_write(word_addr(SRegion, $urandom_range(63)), $urandom);
      end else begin
        host_read_check(word_addr(SRegion, $urandom_range(63)));
      end
    end
    for (int j = 0; j < NumJobs; j++) begin
      random_job((j % 3) == 1, (j % 5) == 2, 1'b0);
    end
    random_job(1'b0, 1'b0, 1'b1);
    random_job(1'b0, 1'b1, 1'b1);
    $display("Errors: %0d value, %0d timeout", value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
source/mm_pkg.sv
source/mm_scratchpad.sv
source/mm_tcdm_arbiter.sv
source/mm_engine.sv
source/mm_complex.sv
testbench/tb_mm_complex.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in the log
rm -f build.log sim.log
verilator --binary --timing -f compile.f --top-module tb_mm_complex -Mdir obj_dir \
  -o tb_mm_complex > build.log 2>&1 &&
  ./obj_dir/tb_mm_complex > sim.log 2>&1 &&
  cat sim.log &&
  grep -q "Result: PASSED" sim.log &&
  echo "Simulation passed" ||
  { echo "Simulation failed, see build.log and sim.log"; exit 1; }
